// ==== design/bp_pkg.sv ====
`default_nettype none

package bp_pkg;

    // pc width shared by fetch, queue, resolver and predictor
    localparam int PC_BITS = 32;

    // first fetch address out of reset
    localparam logic [PC_BITS-1:0] RESET_PC = 32'h0000_1000;

    // kind of a resolved instruction, reported by the pipeline
    typedef enum logic [1:0] {
        br_none = 2'b00,  // not a control transfer
        br_cond = 2'b01,  // conditional branch
        br_jal  = 2'b10,  // direct jump
        br_jalr = 2'b11   // indirect jump
    } branch_kind_e;

endpackage

`default_nettype wire

// ==== design/bp_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one prediction record per fetched instruction, fetch -> in-flight queue
interface fetch_rec_if #(
    parameter int INDEX_BITS = 5
);
    logic                        push;
    logic [bp_pkg::PC_BITS-1:0]  pc;
    logic [INDEX_BITS-1:0]       pht_index;    // gshare index used for this fetch
    logic                        pred_taken;
    logic [bp_pkg::PC_BITS-1:0]  pred_target;  // next pc that fetch actually used

    modport producer (output push, pc, pht_index, pred_taken, pred_target);
    modport queue    (input  push, pc, pht_index, pred_taken, pred_target);
endinterface

// training info from the resolver back into the predictor
interface pred_update_if #(
    parameter int INDEX_BITS = 5
);
    logic                        update;       // one-cycle strobe per resolve
    bp_pkg::branch_kind_e        kind;
    logic [bp_pkg::PC_BITS-1:0]  pc;
    logic [INDEX_BITS-1:0]       pht_index;
    logic                        actual_taken;
    logic [bp_pkg::PC_BITS-1:0]  actual_target;
    logic                        correct;

    modport resolver  (output update, kind, pc, pht_index, actual_taken,
                       actual_target, correct);
    modport predictor (input  update, kind, pc, pht_index, actual_taken,
                       actual_target, correct);
endinterface

`default_nettype wire

// ==== design/pattern_history_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module pattern_history_table #(
    parameter int INDEX_BITS = 5
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [INDEX_BITS-1:0] rd_index,
    output logic                  rd_taken,
    input  logic                  upd_en,
    input  logic [INDEX_BITS-1:0] upd_index,
    input  logic                  upd_taken
);

    localparam int ENTRIES = 2 ** INDEX_BITS;

    logic [1:0] counters [ENTRIES];

    assign rd_taken = counters[rd_index][1];  // msb is the prediction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ENTRIES; i++) begin
                counters[i] <= 2'b01;  // weakly not taken
            end
        end else if (upd_en) begin
            if (upd_taken) begin
                if (counters[upd_index] != 2'b11) begin
                    counters[upd_index] <= counters[upd_index] + 2'd1;
                end
            end else begin
                if (counters[upd_index] != 2'b00) begin
                    counters[upd_index] <= counters[upd_index] - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/gshare_predictor.sv ====
`timescale 1ns/1ps
`default_nettype none

module gshare_predictor #(
    parameter int INDEX_BITS = 5
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [bp_pkg::PC_BITS-1:0] pc,
    output logic [bp_pkg::PC_BITS-1:0] next_pc,
    output logic [INDEX_BITS-1:0]      pht_index,
    output logic                       pred_taken,
    pred_update_if.predictor           upd
);

    localparam int ENTRIES = 2 ** INDEX_BITS;

    logic [INDEX_BITS-1:0]      history;              // global history, newest at msb
    logic [bp_pkg::PC_BITS-1:0] btb      [ENTRIES];
    logic [bp_pkg::PC_BITS-1:0] tag_table[ENTRIES];   // full pc per entry

    logic [INDEX_BITS-1:0]      btb_index;
    logic [INDEX_BITS-1:0]      wr_index;
    logic                       pht_taken;
    logic                       tag_hit;
    logic                       pht_upd_en;
    logic                       btb_write;

    assign btb_index = pc[INDEX_BITS+1:2];
    assign wr_index  = upd.pc[INDEX_BITS+1:2];
    assign pht_index = history ^ btb_index;   // gshare hash

    pattern_history_table #(
        .INDEX_BITS(INDEX_BITS)
    ) u_pht (
        .clk      (clk),
        .reset    (reset),
        .rd_index (pht_index),
        .rd_taken (pht_taken),
        .upd_en   (pht_upd_en),
        .upd_index(upd.pht_index),
        .upd_taken(upd.actual_taken)
    );

    // only a tagged entry can predict taken
    assign tag_hit    = (tag_table[btb_index] == pc);
    assign pred_taken = pht_taken && tag_hit;
    assign next_pc    = pred_taken ? btb[btb_index] : pc + 4;

    assign pht_upd_en = upd.update && (upd.kind == bp_pkg::br_cond);

    always_comb begin
        btb_write = 1'b0;
        if (upd.update) begin
            case (upd.kind)
                bp_pkg::br_cond: btb_write = !upd.correct;  // learn target on a miss
                bp_pkg::br_jal,
                bp_pkg::br_jalr: btb_write = 1'b1;
                default:         btb_write = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            history <= '0;
        end else if (pht_upd_en) begin
            history <= {upd.actual_taken, history[INDEX_BITS-1:1]};  // shift right
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ENTRIES; i++) begin
                btb[i]       <= '0;
                tag_table[i] <= '1;  // matches no aligned pc
            end
        end else if (btb_write) begin
            btb[wr_index]       <= upd.actual_target;
            tag_table[wr_index] <= upd.pc;
        end
    end

endmodule

`default_nettype wire

// ==== design/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter int INDEX_BITS = 5
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       stall,
    input  logic                       queue_full,
    input  logic                       redirect,
    input  logic [bp_pkg::PC_BITS-1:0] redirect_pc,
    input  logic [bp_pkg::PC_BITS-1:0] pred_next_pc,
    input  logic [INDEX_BITS-1:0]      pred_pht_index,
    input  logic                       pred_taken,
    output logic [bp_pkg::PC_BITS-1:0] pc,
    output logic                       fetch_valid,
    fetch_rec_if.producer              rec
);

    logic advance;

    // redirect beats stall, and the wrong-path fetch is dropped
    assign advance     = !reset && !stall && !queue_full && !redirect;
    assign fetch_valid = advance;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= bp_pkg::RESET_PC;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (advance) begin
            pc <= pred_next_pc;
        end
    end

    // record what was predicted for this pc
    assign rec.push        = advance;
    assign rec.pc          = pc;
    assign rec.pht_index   = pred_pht_index;
    assign rec.pred_taken  = pred_taken;
    assign rec.pred_target = pred_next_pc;

endmodule

`default_nettype wire

// ==== design/inflight_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module inflight_queue #(
    parameter int INDEX_BITS  = 5,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                       clk,
    input  logic                       reset,
    fetch_rec_if.queue                 rec_in,
    input  logic                       pop,
    input  logic                       flush,
    output logic                       full,
    output logic                       empty,
    output logic [bp_pkg::PC_BITS-1:0] head_pc,
    output logic [INDEX_BITS-1:0]      head_pht_index,
    output logic                       head_pred_taken,
    output logic [bp_pkg::PC_BITS-1:0] head_pred_target
);

    localparam int PTR_BITS = $clog2(QUEUE_DEPTH);

    logic [bp_pkg::PC_BITS-1:0] pc_mem     [QUEUE_DEPTH];
    logic [INDEX_BITS-1:0]      index_mem  [QUEUE_DEPTH];
    logic                       taken_mem  [QUEUE_DEPTH];
    logic [bp_pkg::PC_BITS-1:0] target_mem [QUEUE_DEPTH];

    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS:0]   count;
    logic                do_push;
    logic                do_pop;

    assign full    = (count == (PTR_BITS+1)'(QUEUE_DEPTH));
    assign empty   = (count == '0);
    assign do_push = rec_in.push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;  // pointers wrap at depth
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop)      count <= count + 1'b1;
            else if (do_pop && !do_push) count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            pc_mem[wr_ptr]     <= rec_in.pc;
            index_mem[wr_ptr]  <= rec_in.pht_index;
            taken_mem[wr_ptr]  <= rec_in.pred_taken;
            target_mem[wr_ptr] <= rec_in.pred_target;
        end
    end

    assign head_pc          = pc_mem[rd_ptr];
    assign head_pht_index   = index_mem[rd_ptr];
    assign head_pred_taken  = taken_mem[rd_ptr];
    assign head_pred_target = target_mem[rd_ptr];

endmodule

`default_nettype wire

// ==== design/branch_resolver.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_resolver #(
    parameter int INDEX_BITS = 5
) (
    input  logic                       resolve,
    input  bp_pkg::branch_kind_e       kind,
    input  logic                       actual_taken,
    input  logic [bp_pkg::PC_BITS-1:0] actual_target,
    input  logic                       empty,
    input  logic [bp_pkg::PC_BITS-1:0] head_pc,
    input  logic [INDEX_BITS-1:0]      head_pht_index,
    input  logic                       head_pred_taken,
    input  logic [bp_pkg::PC_BITS-1:0] head_pred_target,
    output logic                       pop,
    output logic                       flush,
    output logic                       redirect,
    output logic [bp_pkg::PC_BITS-1:0] redirect_pc,
    pred_update_if.resolver            upd
);

    logic valid;
    logic target_match;
    logic correct;
    logic mispredict;

    assign valid        = resolve && !empty;  // resolve on empty queue is dropped
    assign target_match = (head_pred_target == actual_target);

    always_comb begin
        case (kind)
            bp_pkg::br_cond:
                correct = (head_pred_taken == actual_taken) &&
                          (!actual_taken || target_match);
            bp_pkg::br_jal,
            bp_pkg::br_jalr:
                correct = head_pred_taken && target_match;
            default:
                correct = !head_pred_taken;  // plain instruction must fall through
        endcase
    end

    assign mispredict  = valid && !correct;
    assign pop         = valid;
    assign flush       = mispredict;  // everything younger is wrong path
    assign redirect    = mispredict;
    assign redirect_pc = actual_taken ? actual_target : head_pc + 4;

    assign upd.update        = valid;
    assign upd.kind          = kind;
    assign upd.pc            = head_pc;
    assign upd.pht_index     = head_pht_index;
    assign upd.actual_taken  = actual_taken;
    assign upd.actual_target = actual_target;
    assign upd.correct       = correct;

endmodule

`default_nettype wire

// ==== design/branch_predict_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_predict_top #(
    parameter int INDEX_BITS  = 5,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       stall,
    input  logic                       resolve,
    input  bp_pkg::branch_kind_e       res_kind,
    input  logic                       res_taken,
    input  logic [bp_pkg::PC_BITS-1:0] res_target,
    output logic [bp_pkg::PC_BITS-1:0] fetch_pc,
    output logic                       fetch_valid,
    output logic                       fetch_pred_taken,
    output logic                       redirect,
    output logic [bp_pkg::PC_BITS-1:0] redirect_pc,
    output logic                       queue_full
);

    fetch_rec_if   #(.INDEX_BITS(INDEX_BITS)) rec_bus ();
    pred_update_if #(.INDEX_BITS(INDEX_BITS)) upd_bus ();

    logic [bp_pkg::PC_BITS-1:0] pred_next_pc;
    logic [INDEX_BITS-1:0]      pred_pht_index;
    logic                       queue_empty;
    logic                       pop;
    logic                       flush;
    logic [bp_pkg::PC_BITS-1:0] head_pc;
    logic [INDEX_BITS-1:0]      head_pht_index;
    logic                       head_pred_taken;
    logic [bp_pkg::PC_BITS-1:0] head_pred_target;

    gshare_predictor #(.INDEX_BITS(INDEX_BITS)) u_predictor (
        .clk(clk), .reset(reset), .pc(fetch_pc), .next_pc(pred_next_pc),
        .pht_index(pred_pht_index), .pred_taken(fetch_pred_taken), .upd(upd_bus)
    );

    fetch_unit #(.INDEX_BITS(INDEX_BITS)) u_fetch (
        .clk(clk), .reset(reset), .stall(stall), .queue_full(queue_full),
        .redirect(redirect), .redirect_pc(redirect_pc), .pred_next_pc(pred_next_pc),
        .pred_pht_index(pred_pht_index), .pred_taken(fetch_pred_taken),
        .pc(fetch_pc), .fetch_valid(fetch_valid), .rec(rec_bus)
    );

    inflight_queue #(.INDEX_BITS(INDEX_BITS), .QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
        .clk(clk), .reset(reset), .rec_in(rec_bus), .pop(pop), .flush(flush),
        .full(queue_full), .empty(queue_empty), .head_pc(head_pc),
        .head_pht_index(head_pht_index), .head_pred_taken(head_pred_taken),
        .head_pred_target(head_pred_target)
    );

    branch_resolver #(.INDEX_BITS(INDEX_BITS)) u_resolver (
        .resolve(resolve), .kind(res_kind), .actual_taken(res_taken),
        .actual_target(res_target), .empty(queue_empty), .head_pc(head_pc),
        .head_pht_index(head_pht_index), .head_pred_taken(head_pred_taken),
        .head_pred_target(head_pred_target), .pop(pop), .flush(flush),
        .redirect(redirect), .redirect_pc(redirect_pc), .upd(upd_bus)
    );

endmodule

`default_nettype wire

// ==== tb/branch_predict_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_predict_chk (
    input logic clk,
    input logic reset,
    input logic stall,
    input logic fetch_valid,
    input logic queue_full,
    input logic queue_empty,
    input logic redirect
);

    // a push is the same as fetch_valid
    a_no_push_full: assert property (@(posedge clk) disable iff (reset)
        fetch_valid |-> !queue_full)
        else $error("record pushed into a full in-flight queue");

    a_stall_holds: assert property (@(posedge clk) disable iff (reset)
        stall |-> !fetch_valid)
        else $error("fetch_valid high while stalled");

    a_redirect_needs_head: assert property (@(posedge clk) disable iff (reset)
        redirect |-> !queue_empty)
        else $error("redirect raised with an empty in-flight queue");

    a_no_redirect_in_reset: assert property (@(posedge clk)
        reset |-> !redirect)
        else $error("redirect raised during reset");

endmodule

bind branch_predict_top branch_predict_chk chk_i (
    .clk(clk), .reset(reset), .stall(stall), .fetch_valid(fetch_valid),
    .queue_full(queue_full), .queue_empty(queue_empty), .redirect(redirect)
);

`default_nettype wire

// ==== tb/branch_predict_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_predict_tb;

    localparam int INDEX_BITS  = 5;
    localparam int QUEUE_DEPTH = 4;
    localparam int ENTRIES     = 2 ** INDEX_BITS;
    localparam int NUM_CYCLES  = 3000;
    localparam int DRAIN_LIMIT = 4 * QUEUE_DEPTH;

    typedef struct packed {
        logic [31:0]           pc;
        logic [INDEX_BITS-1:0] idx;
        logic                  taken;
        logic [31:0]           target;
    } rec_t;

    logic                 clk;
    logic                 reset;
    logic                 stall;
    logic                 resolve;
    bp_pkg::branch_kind_e res_kind;
    logic                 res_taken;
    logic [31:0]          res_target;
    logic [31:0]          fetch_pc;
    logic                 fetch_valid;
    logic                 fetch_pred_taken;
    logic                 redirect;
    logic [31:0]          redirect_pc;
    logic                 queue_full;

    // reference model state
    logic [31:0]           m_pc;
    logic [INDEX_BITS-1:0] m_hist;     // newest outcome at msb
    logic [1:0]            m_cnt [ENTRIES];
    logic [31:0]           m_btb [ENTRIES];
    logic [31:0]           m_tag [ENTRIES];
    rec_t                  mq[$];      // in-flight records with the oldest first

    logic [31:0] rng;
    int          errors;
    int          checks;
    int          drain_cycles;

    branch_predict_top #(
        .INDEX_BITS (INDEX_BITS),
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) branch_predict_top_i (
        .clk(clk), .reset(reset), .stall(stall), .resolve(resolve),
        .res_kind(res_kind), .res_taken(res_taken), .res_target(res_target),
        .fetch_pc(fetch_pc), .fetch_valid(fetch_valid),
        .fetch_pred_taken(fetch_pred_taken), .redirect(redirect),
        .redirect_pc(redirect_pc), .queue_full(queue_full)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic model_reset();
        m_pc   = bp_pkg::RESET_PC;
        m_hist = '0;
        for (int i = 0; i < ENTRIES; i++) begin
            m_cnt[i] = 2'b01;
            m_btb[i] = '0;
            m_tag[i] = '1;
        end
        mq.delete();
    endtask

    task automatic pick_stimulus();
        rng = xorshift(rng);
        stall    = (rng[2:0] == 3'd0);
        resolve  = (mq.size() != 0) && rng[3];  // only with something in flight
        res_kind = bp_pkg::branch_kind_e'(rng[6:5]);
        case (res_kind)
            bp_pkg::br_cond: res_taken = (rng[8:7] != 2'd0);  // mostly taken
            bp_pkg::br_none: res_taken = 1'b0;
            default:         res_taken = 1'b1;
        endcase
        res_target = bp_pkg::RESET_PC + 32'({rng[12:9], 2'b00});  // small pool
    endtask

    // compare this cycle's outputs and then step the model past the edge
    task automatic check_and_step();
        logic [INDEX_BITS-1:0] bidx;
        logic [INDEX_BITS-1:0] idx;
        logic [INDEX_BITS-1:0] widx;
        logic                  ptaken;
        logic                  full;
        logic                  valid;
        logic                  correct;
        logic                  mis;
        logic                  fvalid;
        logic [31:0]           pnext;
        logic [31:0]           rpc;
        rec_t                  head;
        rec_t                  newrec;
        bidx    = m_pc[INDEX_BITS+1:2];
        idx     = m_hist ^ bidx;
        ptaken  = m_cnt[idx][1] && (m_tag[bidx] == m_pc);
        pnext   = ptaken ? m_btb[bidx] : m_pc + 32'd4;
        full    = (mq.size() == QUEUE_DEPTH);
        valid   = resolve && (mq.size() != 0);
        head    = '0;
        correct = 1'b1;
        if (valid) begin
            head = mq[0];
            case (res_kind)
                bp_pkg::br_cond:
                    correct = (head.taken == res_taken) &&
                              (!res_taken || head.target == res_target);
                bp_pkg::br_jal, bp_pkg::br_jalr:
                    correct = head.taken && (head.target == res_target);
                default:
                    correct = !head.taken;
            endcase
        end
        mis    = valid && !correct;
        rpc    = res_taken ? res_target : head.pc + 32'd4;
        fvalid = !stall && !full && !mis;
        check_value("fetch_pc", fetch_pc, m_pc);
        check_value("fetch_pred_taken", 32'(fetch_pred_taken), 32'(ptaken));
        check_value("queue_full", 32'(queue_full), 32'(full));
        check_value("fetch_valid", 32'(fetch_valid), 32'(fvalid));
        check_value("redirect", 32'(redirect), 32'(mis));
        if (mis) begin
            check_value("redirect_pc", redirect_pc, rpc);
        end
        if (valid) begin
            void'(mq.pop_front());
            widx = head.pc[INDEX_BITS+1:2];
            if (res_kind == bp_pkg::br_cond) begin
                if (res_taken && m_cnt[head.idx] != 2'b11) begin
                    m_cnt[head.idx] = m_cnt[head.idx] + 2'd1;
                end else if (!res_taken && m_cnt[head.idx] != 2'b00) begin
                    m_cnt[head.idx] = m_cnt[head.idx] - 2'd1;
                end
                m_hist = {res_taken, m_hist[INDEX_BITS-1:1]};
            end
            if ((res_kind == bp_pkg::br_cond && !correct) ||
                res_kind == bp_pkg::br_jal || res_kind == bp_pkg::br_jalr) begin
                m_btb[widx] = res_target;
                m_tag[widx] = head.pc;
            end
        end
        if (mis) begin
            m_pc = rpc;
            mq.delete();  // wrong-path records dropped
        end else if (fvalid) begin
            newrec.pc     = m_pc;
            newrec.idx    = idx;
            newrec.taken  = ptaken;
            newrec.target = pnext;
            mq.push_back(newrec);
            m_pc = pnext;
        end
    endtask

    initial begin
        rng        = 32'h9e38be27;
        errors     = 0;
        checks     = 0;
        reset      = 1'b1;
        stall      = 1'b0;
        resolve    = 1'b0;
        res_kind   = bp_pkg::br_none;
        res_taken  = 1'b0;
        res_target = '0;
        model_reset();
        repeat (3) @(posedge clk);
        #1;
        // state held while reset is still high
        check_value("fetch_pc in reset", fetch_pc, bp_pkg::RESET_PC);
        check_value("fetch_valid in reset", 32'(fetch_valid), 32'd0);
        check_value("redirect in reset", 32'(redirect), 32'd0);
        check_value("queue_full in reset", 32'(queue_full), 32'd0);
        reset = 1'b0;
        #4;
        check_and_step();
        for (int c = 0; c < NUM_CYCLES; c++) begin
            @(posedge clk);
            #1;
            pick_stimulus();
            #4;
            check_and_step();
        end
        // resolve everything still in flight
        drain_cycles = 0;
        while (mq.size() != 0 && drain_cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            #1;
            stall     = 1'b1;
            resolve   = 1'b1;
            res_kind  = bp_pkg::br_none;
            res_taken = 1'b0;
            #4;
            check_and_step();
            drain_cycles++;
        end
        if (mq.size() != 0) begin
            errors++;
            $display("Timeout: %0d records still in flight after %0d drain cycles",
                     mq.size(), drain_cycles);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== branch_predict.f ====
design/bp_pkg.sv
design/bp_if.sv
design/pattern_history_table.sv
design/gshare_predictor.sv
design/fetch_unit.sv
design/inflight_queue.sv
design/branch_resolver.sv
design/branch_predict_top.sv
tb/branch_predict_chk.sv
tb/branch_predict_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the branch predictor testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module branch_predict_tb \
    -f branch_predict.f -o branch_predict_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/branch_predict_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^All tests passed$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
